//--- include/writeback_cfg.svh
`ifndef WRITEBACK_CFG_SVH
`define WRITEBACK_CFG_SVH

// data memory address width
`define WB_ADDR_W 32

// execute result and memory write data width
`define WB_DATA_W 64

// general register data width
`define WB_REG_W 32

// register number width, eight registers
`define WB_REG_NUM_W 3

// number of commit records the queue can hold
`define WB_FIFO_DEPTH 4

// alu opcode of the exchange instruction
`define WB_XCHG_OP 14

`endif

//--- rtl/writeback_pkg.sv
`include "writeback_cfg.svh"

package writeback_pkg;

   // execute alu opcodes
   // only the exchange changes how a result is written back
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_or   = 4'd1,
      alu_adc  = 4'd2,
      alu_sbb  = 4'd3,
      alu_and  = 4'd4,
      alu_sub  = 4'd5,
      alu_xor  = 4'd6,
      alu_cmp  = 4'd7,
      alu_mov  = 4'd8,
      alu_xchg = 4'(`WB_XCHG_OP)
   } alu_op_e;

   // operand size code as delivered by execute
   typedef logic [2:0] op_size_t;

   // size code on the data memory write port
   typedef logic [1:0] mem_size_t;

   // everything one commit writes, register and memory side
   typedef struct packed {
      logic                     reg_en;
      logic [`WB_REG_NUM_W-1:0] reg_number;
      op_size_t                 reg_size;
      logic [`WB_REG_W-1:0]     reg_data;
      logic                     reg2_en;
      logic [`WB_REG_NUM_W-1:0] reg2_number;
      logic [`WB_REG_W-1:0]     reg2_data;
      logic                     mem_en;
      logic [`WB_ADDR_W-1:0]    mem_address;
      logic [`WB_DATA_W-1:0]    mem_data;
      mem_size_t                mem_size;
   } commit_rec_t;

endpackage

//--- rtl/result_capture.sv
`include "writeback_cfg.svh"

module result_capture (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       wb_valid,
   input  writeback_pkg::alu_op_e     wb_alu_op,
   input  writeback_pkg::op_size_t    wb_opsize,
   input  logic [`WB_DATA_W-1:0]      wb_result,
   input  logic [`WB_REG_W-1:0]       wb_dest_reg,
   input  logic [`WB_ADDR_W-1:0]      wb_dest_address,
   input  logic                       wb_op_a_is_reg,
   input  logic                       wb_op_a_is_address,
   input  logic [`WB_REG_NUM_W-1:0]   wb_op_b_reg,
   input  logic                       wb_op_b_is_reg,
   input  logic                       wb_op_b_is_address,
   input  logic [`WB_ADDR_W-1:0]      wb_op_b_address,
   input  logic                       full,
   output logic                       wb_ready,
   output logic                       push,
   output writeback_pkg::commit_rec_t push_rec
);

   logic                       held;
   writeback_pkg::commit_rec_t held_rec;
   writeback_pkg::commit_rec_t next_rec;
   logic                       accept;
   logic                       is_xchg;
   logic                       xchg_to_mem;

   // operand size to memory size code
   function automatic writeback_pkg::mem_size_t map_size(
      input writeback_pkg::op_size_t opsize
   );
      writeback_pkg::mem_size_t size;
      case (opsize)
         3'd1:    size = 2'd2;
         3'd2:    size = 2'd3;
         3'd5:    size = 2'd1;
         default: size = 2'd0;
      endcase
      return size;
   endfunction

   assign is_xchg     = (wb_alu_op == writeback_pkg::alu_xchg);
   assign xchg_to_mem = is_xchg && wb_op_b_is_address;

   // build the commit record straight from the execute fields
   always_comb begin
      next_rec.reg_en      = wb_op_a_is_reg;
      next_rec.reg_number  = wb_dest_reg[`WB_REG_NUM_W-1:0];
      next_rec.reg_size    = wb_opsize;
      next_rec.reg_data    = wb_result[`WB_REG_W-1:0];

      // second register is only used by an exchange and gets the upper half
      next_rec.reg2_en     = is_xchg && wb_op_b_is_reg;
      next_rec.reg2_number = wb_op_b_reg;
      next_rec.reg2_data   = wb_result[`WB_DATA_W-1:`WB_REG_W];

      next_rec.mem_en      = wb_op_a_is_address || xchg_to_mem;
      if (xchg_to_mem) begin
         // exchange with memory writes the upper half to operand b
         next_rec.mem_address = wb_op_b_address;
         next_rec.mem_data    = {{(`WB_DATA_W - `WB_REG_W){1'b0}},
                                 wb_result[`WB_DATA_W-1:`WB_REG_W]};
      end else begin
         next_rec.mem_address = wb_dest_address;
         next_rec.mem_data    = wb_result;
      end
      next_rec.mem_size    = map_size(wb_opsize);
   end

   // one-entry slice in front of the queue
   assign push     = held && !full;
   assign wb_ready = !held || push;
   assign accept   = wb_valid && wb_ready;
   assign push_rec = held_rec;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         held <= 1'b0;
      end else if (accept) begin
         held <= 1'b1;
      end else if (push) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         held_rec <= next_rec;
      end
   end

   // queue only fills right after a push from this slice
   full_after_push_a: assert property (
      @(posedge clk) disable iff (!rst_n) $rose(full) |-> $past(push)
   );

endmodule

//--- rtl/commit_fifo.sv
`include "writeback_cfg.svh"

module commit_fifo (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       push,
   input  writeback_pkg::commit_rec_t push_rec,
   input  logic                       pop,
   output writeback_pkg::commit_rec_t head_rec,
   output logic                       empty,
   output logic                       full
);

   localparam int DEPTH = `WB_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   writeback_pkg::commit_rec_t entries [DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]           count;

   // wrap at depth, depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      logic [PTR_W-1:0] nxt;
      if (ptr == PTR_W'(DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign empty    = (count == '0);
   assign full     = (count == CNT_W'(DEPTH));
   assign head_rec = entries[rd_ptr];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= push_rec;
      end
   end

   // writer only pops a head that exists
   no_pop_empty_a: assert property (
      @(posedge clk) disable iff (!rst_n) pop |-> !empty
   );

   no_push_full_a: assert property (
      @(posedge clk) disable iff (!rst_n) push |-> !full
   );

endmodule

//--- rtl/commit_writer.sv
`include "writeback_cfg.svh"

module commit_writer (
   input  logic                       clk,
   input  logic                       rst_n,
   input  writeback_pkg::commit_rec_t head_rec,
   input  logic                       empty,
   input  logic                       dec_wb_valid,
   input  logic [`WB_REG_NUM_W-1:0]   dec_wb_reg,
   input  logic [`WB_REG_W-1:0]       dec_wb_data,
   input  writeback_pkg::op_size_t    dec_wb_size,
   input  logic                       wmem_ready,
   output logic                       pop,
   output logic                       reg_en,
   output logic [`WB_REG_NUM_W-1:0]   reg_number,
   output writeback_pkg::op_size_t    reg_size,
   output logic [`WB_REG_W-1:0]       reg_data,
   output logic                       reg2_en,
   output logic [`WB_REG_NUM_W-1:0]   reg2_number,
   output logic [`WB_REG_W-1:0]       reg2_data,
   output logic                       wmem_valid,
   output logic                       wmem_wr_en,
   output logic [`WB_ADDR_W-1:0]      wmem_address,
   output logic [`WB_DATA_W-1:0]      wmem_wr_data,
   output writeback_pkg::mem_size_t   wmem_wr_size
);

   logic mem_clear;
   logic reg_clear;
   logic commit;
   logic head_reg_wr;
   logic head_mem_wr;

   // head may go when memory can take it and decode is not on the reg port
   assign mem_clear   = wmem_ready || !head_rec.mem_en;
   assign reg_clear   = !dec_wb_valid || !head_rec.reg_en;
   assign commit      = !empty && mem_clear && reg_clear;
   assign pop         = commit;
   assign head_reg_wr = commit && head_rec.reg_en;
   assign head_mem_wr = commit && head_rec.mem_en;

   // strobes, one cycle per commit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_en     <= 1'b0;
         reg2_en    <= 1'b0;
         wmem_valid <= 1'b0;
         wmem_wr_en <= 1'b0;
      end else begin
         reg_en     <= dec_wb_valid || head_reg_wr;
         reg2_en    <= commit && head_rec.reg2_en;
         wmem_valid <= head_mem_wr;
         wmem_wr_en <= head_mem_wr;
      end
   end

   // register port payload, decode first
   always_ff @(posedge clk) begin
      if (dec_wb_valid) begin
         reg_number <= dec_wb_reg;
         reg_size   <= dec_wb_size;
         reg_data   <= dec_wb_data;
      end else if (head_reg_wr) begin
         reg_number <= head_rec.reg_number;
         reg_size   <= head_rec.reg_size;
         reg_data   <= head_rec.reg_data;
      end
   end

   // second register and memory payload
   always_ff @(posedge clk) begin
      if (commit) begin
         reg2_number  <= head_rec.reg2_number;
         reg2_data    <= head_rec.reg2_data;
         wmem_address <= head_rec.mem_address;
         wmem_wr_data <= head_rec.mem_data;
         wmem_wr_size <= head_rec.mem_size;
      end
   end

   // memory strobe only follows an edge where the memory was ready
   wmem_after_ready_a: assert property (
      @(posedge clk) disable iff (!rst_n) wmem_valid |-> $past(wmem_ready)
   );

endmodule

//--- rtl/writeback_unit.sv
`include "writeback_cfg.svh"

module writeback_unit (
   input  logic                     clk,
   input  logic                     rst_n,

   // execute results
   input  logic                     wb_valid,
   output logic                     wb_ready,
   input  writeback_pkg::alu_op_e   wb_alu_op,
   input  writeback_pkg::op_size_t  wb_opsize,
   input  logic [`WB_DATA_W-1:0]    wb_result,
   input  logic [`WB_REG_W-1:0]     wb_dest_reg,
   input  logic [`WB_ADDR_W-1:0]    wb_dest_address,
   input  logic                     wb_op_a_is_reg,
   input  logic                     wb_op_a_is_address,
   input  logic [`WB_REG_NUM_W-1:0] wb_op_b_reg,
   input  logic                     wb_op_b_is_reg,
   input  logic                     wb_op_b_is_address,
   input  logic [`WB_ADDR_W-1:0]    wb_op_b_address,

   // decode register writes
   input  logic                     dec_wb_valid,
   input  logic [`WB_REG_NUM_W-1:0] dec_wb_reg,
   input  logic [`WB_REG_W-1:0]     dec_wb_data,
   input  writeback_pkg::op_size_t  dec_wb_size,

   // register file ports
   output logic                     reg_en,
   output logic [`WB_REG_NUM_W-1:0] reg_number,
   output writeback_pkg::op_size_t  reg_size,
   output logic [`WB_REG_W-1:0]     reg_data,
   output logic                     reg2_en,
   output logic [`WB_REG_NUM_W-1:0] reg2_number,
   output logic [`WB_REG_W-1:0]     reg2_data,

   // data memory write port
   output logic                     wmem_valid,
   input  logic                     wmem_ready,
   output logic                     wmem_wr_en,
   output logic [`WB_ADDR_W-1:0]    wmem_address,
   output logic [`WB_DATA_W-1:0]    wmem_wr_data,
   output writeback_pkg::mem_size_t wmem_wr_size
);

   logic                       push;
   writeback_pkg::commit_rec_t push_rec;
   logic                       full;
   logic                       pop;
   writeback_pkg::commit_rec_t head_rec;
   logic                       empty;

   result_capture result_capture_inst (
      .clk                (clk),
      .rst_n              (rst_n),
      .wb_valid           (wb_valid),
      .wb_alu_op          (wb_alu_op),
      .wb_opsize          (wb_opsize),
      .wb_result          (wb_result),
      .wb_dest_reg        (wb_dest_reg),
      .wb_dest_address    (wb_dest_address),
      .wb_op_a_is_reg     (wb_op_a_is_reg),
      .wb_op_a_is_address (wb_op_a_is_address),
      .wb_op_b_reg        (wb_op_b_reg),
      .wb_op_b_is_reg     (wb_op_b_is_reg),
      .wb_op_b_is_address (wb_op_b_is_address),
      .wb_op_b_address    (wb_op_b_address),
      .full               (full),
      .wb_ready           (wb_ready),
      .push               (push),
      .push_rec           (push_rec)
   );

   commit_fifo commit_fifo_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (push),
      .push_rec (push_rec),
      .pop      (pop),
      .head_rec (head_rec),
      .empty    (empty),
      .full     (full)
   );

   commit_writer commit_writer_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .head_rec     (head_rec),
      .empty        (empty),
      .dec_wb_valid (dec_wb_valid),
      .dec_wb_reg   (dec_wb_reg),
      .dec_wb_data  (dec_wb_data),
      .dec_wb_size  (dec_wb_size),
      .wmem_ready   (wmem_ready),
      .pop          (pop),
      .reg_en       (reg_en),
      .reg_number   (reg_number),
      .reg_size     (reg_size),
      .reg_data     (reg_data),
      .reg2_en      (reg2_en),
      .reg2_number  (reg2_number),
      .reg2_data    (reg2_data),
      .wmem_valid   (wmem_valid),
      .wmem_wr_en   (wmem_wr_en),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data),
      .wmem_wr_size (wmem_wr_size)
   );

endmodule

//--- bench/writeback_tb.sv
`include "writeback_cfg.svh"

module writeback_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 16;
   localparam int IDLE_CYCLES  = 20;
   localparam int N_PLAIN      = 24;
   localparam int N_XCHG       = 16;
   localparam int N_STALL      = 24;
   localparam int N_MIX        = 20;
   localparam int N_DEC        = 16;
   localparam int DRAIN_LIMIT  = 200;
   // 40 cycles per record and decode write, idle cycles counted the same way
   localparam int CYCLE_LIMIT  =
      40 * (N_PLAIN + N_XCHG + N_STALL + N_MIX + N_DEC + IDLE_CYCLES) + RESET_CYCLES;

   typedef logic [`WB_REG_NUM_W+3+`WB_REG_W-1:0] reg_entry_t;
   typedef logic [`WB_REG_NUM_W+`WB_REG_W-1:0]   reg2_entry_t;
   typedef logic [`WB_ADDR_W+`WB_DATA_W+1:0]     mem_entry_t;

   logic                       clk;
   logic                       rst_n;
   logic                       wb_valid;
   logic                       wb_ready;
   writeback_pkg::alu_op_e     wb_alu_op;
   writeback_pkg::op_size_t    wb_opsize;
   logic [`WB_DATA_W-1:0]      wb_result;
   logic [`WB_REG_W-1:0]       wb_dest_reg;
   logic [`WB_ADDR_W-1:0]      wb_dest_address;
   logic                       wb_op_a_is_reg;
   logic                       wb_op_a_is_address;
   logic [`WB_REG_NUM_W-1:0]   wb_op_b_reg;
   logic                       wb_op_b_is_reg;
   logic                       wb_op_b_is_address;
   logic [`WB_ADDR_W-1:0]      wb_op_b_address;
   logic                       dec_wb_valid;
   logic [`WB_REG_NUM_W-1:0]   dec_wb_reg;
   logic [`WB_REG_W-1:0]       dec_wb_data;
   writeback_pkg::op_size_t    dec_wb_size;
   logic                       reg_en;
   logic [`WB_REG_NUM_W-1:0]   reg_number;
   writeback_pkg::op_size_t    reg_size;
   logic [`WB_REG_W-1:0]       reg_data;
   logic                       reg2_en;
   logic [`WB_REG_NUM_W-1:0]   reg2_number;
   logic [`WB_REG_W-1:0]       reg2_data;
   logic                       wmem_valid;
   logic                       wmem_ready;
   logic                       wmem_wr_en;
   logic [`WB_ADDR_W-1:0]      wmem_address;
   logic [`WB_DATA_W-1:0]      wmem_wr_data;
   writeback_pkg::mem_size_t   wmem_wr_size;

   logic [15:0] lfsr_state;
   reg_entry_t  reg_q[$];
   reg_entry_t  dec_q[$];
   reg2_entry_t reg2_q[$];
   mem_entry_t  mem_q[$];
   bit          ready_plan[$];
   logic        ready_at_edge;
   bit          saw_backpressure;
   string       test_name;
   int          errors;
   int          test_errors;
   int          checks;
   int          tests_run;
   int          tests_failed;
   int          cycle_count;
   reg_entry_t  got_reg;
   reg_entry_t  exp_dec;
   reg_entry_t  exp_reg;
   reg2_entry_t exp_reg2;
   mem_entry_t  exp_mem;

   writeback_unit writeback_unit_inst (.*);

   // fibonacci lfsr, taps 16 14 13 11, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] value;
      logic        fb;
      int          k;
      value = '0;
      for (k = 0; k < n; k++) begin
         fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         value      = {value[62:0], fb};
      end
      return value;
   endfunction

   // expected commit for the execute record now on the inputs
   function automatic writeback_pkg::commit_rec_t reference_commit();
      writeback_pkg::commit_rec_t r;
      logic                       to_b_addr;
      to_b_addr     = (wb_alu_op == writeback_pkg::alu_xchg) && wb_op_b_is_address;
      r             = '0;
      r.reg_en      = wb_op_a_is_reg;
      r.reg_number  = wb_dest_reg[`WB_REG_NUM_W-1:0];
      r.reg_size    = wb_opsize;
      r.reg_data    = wb_result[`WB_REG_W-1:0];
      r.reg2_en     = (wb_alu_op == writeback_pkg::alu_xchg) && wb_op_b_is_reg;
      r.reg2_number = wb_op_b_reg;
      r.reg2_data   = wb_result[`WB_DATA_W-1:`WB_REG_W];
      r.mem_en      = wb_op_a_is_address || to_b_addr;
      r.mem_address = to_b_addr ? wb_op_b_address : wb_dest_address;
      r.mem_data    = to_b_addr ? {32'h0, wb_result[`WB_DATA_W-1:`WB_REG_W]} : wb_result;
      case (wb_opsize)
         3'd1:    r.mem_size = 2'd2;
         3'd2:    r.mem_size = 2'd3;
         3'd5:    r.mem_size = 2'd1;
         default: r.mem_size = 2'd0;
      endcase
      return r;
   endfunction

   // drive one execute record and hold it until the unit takes it
   task automatic send_record(input writeback_pkg::alu_op_e op,
                              input writeback_pkg::op_size_t opsize,
                              input logic a_reg, input logic a_addr,
                              input logic b_is_reg, input logic b_is_addr);
      writeback_pkg::commit_rec_t exp;
      bit                         taken;
      wb_alu_op          = op;
      wb_opsize          = opsize;
      wb_result          = rand_bits(64);
      wb_dest_reg        = 32'(rand_bits(32));
      wb_dest_address    = 32'(rand_bits(32));
      wb_op_b_reg        = 3'(rand_bits(3));
      wb_op_b_address    = 32'(rand_bits(32));
      wb_op_a_is_reg     = a_reg;
      wb_op_a_is_address = a_addr;
      wb_op_b_is_reg     = b_is_reg;
      wb_op_b_is_address = b_is_addr;
      wb_valid           = 1'b1;
      exp                = reference_commit();
      taken              = 1'b0;
      while (!taken) begin
         // wb_ready only moves on edges, so the negedge value holds for the next edge
         @(negedge clk);
         taken = wb_ready;
         @(posedge clk);
         #2;
      end
      wb_valid = 1'b0;
      if (exp.reg_en)
         reg_q.push_back({exp.reg_number, exp.reg_size, exp.reg_data});
      if (exp.reg2_en)
         reg2_q.push_back({exp.reg2_number, exp.reg2_data});
      if (exp.mem_en)
         mem_q.push_back({exp.mem_address, exp.mem_data, exp.mem_size});
   endtask

   // one decode strobe followed by a short gap
   task automatic send_decode(input int n);
      dec_wb_valid = 1'b1;
      dec_wb_reg   = 3'(n);
      dec_wb_data  = {16'hdec0, 16'(n)};
      dec_wb_size  = writeback_pkg::op_size_t'(n % 5);
      dec_q.push_back({dec_wb_reg, dec_wb_size, dec_wb_data});
      @(posedge clk);
      #2;
      dec_wb_valid = 1'b0;
      repeat (n % 3) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = errors;
      tests_run++;
   endtask

   // let the queue drain, then check nothing is left over
   task automatic end_test();
      int waited;
      waited = 0;
      while (reg_q.size() + dec_q.size() + reg2_q.size() + mem_q.size() > 0 &&
             waited < DRAIN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      repeat (4) @(negedge clk);
      checks++;
      assert (reg_q.size() + dec_q.size() + reg2_q.size() + mem_q.size() == 0) else begin
         errors++;
         $display("%s: expected writes never appeared on the ports", test_name);
      end
      if (errors == test_errors) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errors - test_errors);
      end
      @(posedge clk);
      #2;
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      ready_at_edge <= wmem_ready;
   end

   // compare each strobe with the head of its queue
   always @(negedge clk) begin
      if (rst_n) begin
         if (!wb_ready)
            saw_backpressure = 1'b1;
         if (reg_en) begin
            checks++;
            got_reg = {reg_number, reg_size, reg_data};
            exp_dec = (dec_q.size() > 0) ? dec_q[0] : 'x;
            exp_reg = (reg_q.size() > 0) ? reg_q[0] : 'x;
            // decode and commit writes interleave, either head may match
            if (exp_dec === got_reg)
               void'(dec_q.pop_front());
            else if (exp_reg === got_reg)
               void'(reg_q.pop_front());
            assert (exp_dec === got_reg || exp_reg === got_reg) else begin
               errors++;
               $display("FAIL %s reg port expected %h or %h actual %h",
                        test_name, exp_dec, exp_reg, got_reg);
            end
         end
         if (reg2_en) begin
            checks++;
            exp_reg2 = (reg2_q.size() > 0) ? reg2_q.pop_front() : 'x;
            assert ({reg2_number, reg2_data} === exp_reg2) else begin
               errors++;
               $display("FAIL %s reg2 port expected %h actual %h",
                        test_name, exp_reg2, {reg2_number, reg2_data});
            end
         end
         if (wmem_valid) begin
            checks++;
            exp_mem = (mem_q.size() > 0) ? mem_q.pop_front() : 'x;
            assert ({wmem_address, wmem_wr_data, wmem_wr_size} === exp_mem) else begin
               errors++;
               $display("FAIL %s memory port expected %h actual %h",
                        test_name, exp_mem, {wmem_address, wmem_wr_data, wmem_wr_size});
            end
            assert (ready_at_edge && wmem_wr_en) else begin
               errors++;
               $display("%s: wmem_valid without wmem_ready on the prior edge or wr_en",
                        test_name);
            end
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the tests did not complete", cycle_count);
      $display("*** FAILED ***");
      $finish;
   end

   initial begin
      int                      i;
      int                      j;
      int                      run;
      logic [3:0]              flags;
      writeback_pkg::alu_op_e  op;
      writeback_pkg::op_size_t opsize;
      rst_n              = 1'b0;
      wb_valid           = 1'b0;
      wb_alu_op          = writeback_pkg::alu_add;
      wb_opsize          = '0;
      wb_result          = '0;
      wb_dest_reg        = '0;
      wb_dest_address    = '0;
      wb_op_a_is_reg     = 1'b0;
      wb_op_a_is_address = 1'b0;
      wb_op_b_reg        = '0;
      wb_op_b_is_reg     = 1'b0;
      wb_op_b_is_address = 1'b0;
      wb_op_b_address    = '0;
      dec_wb_valid       = 1'b0;
      dec_wb_reg         = '0;
      dec_wb_data        = '0;
      dec_wb_size        = '0;
      wmem_ready         = 1'b1;
      lfsr_state         = 16'd1519;
      errors             = 0;
      checks             = 0;
      tests_run          = 0;
      tests_failed       = 0;
      saw_backpressure   = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;

      start_test("idle_after_reset");
      repeat (IDLE_CYCLES) begin
         @(negedge clk);
         checks++;
         assert (!reg_en && !reg2_en && !wmem_valid && wb_ready) else begin
            errors++;
            $display("%s: strobe seen or wb_ready low with no input", test_name);
         end
      end
      end_test();

      // first eight records all write memory so every opsize reaches the port
      start_test("plain_writes");
      for (i = 0; i < N_PLAIN; i++) begin
         op    = writeback_pkg::alu_op_e'(rand_bits(3));
         flags = 4'(rand_bits(4));
         send_record(op, 3'(i % 8), flags[0], (i < 8) || flags[1], flags[2], flags[3]);
      end
      end_test();

      start_test("exchange");
      for (i = 0; i < N_XCHG; i++) begin
         flags  = 4'(rand_bits(4));
         opsize = 3'(rand_bits(3));
         if (i % 2 == 0)
            send_record(writeback_pkg::alu_xchg, opsize, 1'b1, flags[1], 1'b1, 1'b0);
         else
            send_record(writeback_pkg::alu_xchg, opsize, flags[0], flags[1], 1'b0, 1'b1);
      end
      end_test();

      // low stretches long enough to fill the slice and the queue
      start_test("memory_stall");
      saw_backpressure = 1'b0;
      ready_plan.delete();
      while (ready_plan.size() < N_STALL * 10) begin
         run = int'(rand_bits(3)) + 4;
         repeat (run) ready_plan.push_back(1'b0);
         run = int'(rand_bits(2)) + 1;
         repeat (run) ready_plan.push_back(1'b1);
      end
      fork
         begin
            foreach (ready_plan[k]) begin
               wmem_ready = ready_plan[k];
               @(posedge clk);
               #2;
            end
            wmem_ready = 1'b1;
         end
         for (i = 0; i < N_STALL; i++) begin
            op     = writeback_pkg::alu_op_e'(rand_bits(3));
            opsize = 3'(rand_bits(3));
            flags  = 4'(rand_bits(4));
            send_record(op, opsize, flags[0], 1'b1, flags[2], flags[3]);
         end
      join
      checks++;
      assert (saw_backpressure) else begin
         errors++;
         $display("%s: wb_ready never dropped while the memory was stalled", test_name);
      end
      end_test();

      start_test("decode_mix");
      fork
         for (j = 0; j < N_DEC; j++) begin
            send_decode(j);
         end
         for (i = 0; i < N_MIX; i++) begin
            op     = writeback_pkg::alu_op_e'(rand_bits(3));
            opsize = 3'(rand_bits(3));
            flags  = 4'(rand_bits(4));
            send_record(op, opsize, 1'b1, flags[1], 1'b0, 1'b0);
         end
      join
      end_test();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- writeback_unit.f
+incdir+include
rtl/writeback_pkg.sv
rtl/result_capture.sv
rtl/commit_fifo.sv
rtl/commit_writer.sv
rtl/writeback_unit.sv
bench/writeback_tb.sv

//--- Bender.yml
package:
  name: writeback_unit

export_include_dirs:
  - include

sources:
  - rtl/writeback_pkg.sv
  - rtl/result_capture.sv
  - rtl/commit_fifo.sv
  - rtl/commit_writer.sv
  - rtl/writeback_unit.sv
  - target: test
    files:
      - bench/writeback_tb.sv
